//--- hacd_comp_pkg.sv
/*
 * page geometry and zero-chunk compression constants, the control unit
 * state encoding and the result reported after each compressed page
 */
`default_nettype none

package hacd_comp_pkg;

   localparam int CHUNK_W         = 16;  // bits per chunk
   localparam int CHUNKS_PER_LINE = 4;
   localparam int LINES_PER_PAGE  = 8;
   localparam int CHUNK_BYTES     = 2;
   localparam int PAGE_CHUNKS     = CHUNKS_PER_LINE * LINES_PER_PAGE;  // 32
   localparam int SIZE_W          = 7;   // holds 0..64 bytes
   localparam int INCOMP_BYTES    = 48;  // above this, not worth storing

   //////////////////////////////////////////////////////////////////////
   // control unit states
   //////////////////////////////////////////////////////////////////////
   typedef enum logic [1:0] {
      CU_IDLE,    // port belongs to cpu
      CU_DRAIN,   // wait for cpu reads to come home
      CU_COMP,    // engine owns the port
      CU_DONE     // one cycle, result out
   } ctrl_state_e;

   typedef struct packed {
      logic [SIZE_W-1:0] size;            // compressed bytes
      logic              incompressible;
   } comp_result_t;

endpackage

`default_nettype wire

//--- hacd_core.sv
/*
 * top of the compression block between CPU and memory controller.
 * connects the CPU stall unit, the memory port mux, the zero-chunk
 * engine and the control FSM
 */
`default_nettype none

module hacd_core
   import hacd_mem_pkg::*;
   import hacd_comp_pkg::*;
(
   input  wire logic        clk_i,
   input  wire logic        rst_i,
   input  wire logic        hawk_inactive_i,
   // cpu side
   input  wire mem_req_t    cpu_req_i,
   output mem_resp_t        cpu_resp_o,
   output logic             cpu_stalled_o,
   // compression control
   input  wire logic        comp_req_i,
   input  wire [ADDR_W-1:0] comp_page_i,
   output logic             comp_busy_o,
   output logic             comp_done_o,
   output comp_result_t     comp_result_o,
   // memory side
   output mem_req_t         mem_req_o,
   input  wire mem_resp_t   mem_resp_i
);

   mem_req_t          stall_req;   // cpu path after the stall unit
   mem_req_t          eng_req;
   mem_resp_t         eng_resp;
   logic              hawk_own;
   logic              start;
   logic              cpu_idle;
   logic              eng_done;
   logic [ADDR_W-1:0] page;

   hacd_cpu_stall u_cpu_stall (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .hawk_own_i      (hawk_own),
      .cpu_req_i       (cpu_req_i),
      .cpu_req_o       (stall_req),
      .cpu_stalled_o   (cpu_stalled_o),
      .cpu_idle_o      (cpu_idle),
      .rd_resp_valid_i (cpu_resp_o.valid)
   );

   hacd_mem_mux u_mem_mux (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .hawk_own_i (hawk_own),
      .cpu_req_i  (stall_req),
      .eng_req_i  (eng_req),
      .mem_req_o  (mem_req_o),
      .mem_resp_i (mem_resp_i),
      .cpu_resp_o (cpu_resp_o),
      .eng_resp_o (eng_resp)
   );

   hacd_zero_comp u_zero_comp (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .start_i    (start),
      .page_i     (page),
      .eng_req_o  (eng_req),
      .eng_resp_i (eng_resp),
      .done_o     (eng_done),
      .result_o   (comp_result_o)
   );

   hacd_ctrl_unit u_ctrl_unit (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .hawk_inactive_i (hawk_inactive_i),
      .comp_req_i      (comp_req_i),
      .comp_page_i     (comp_page_i),
      .cpu_idle_i      (cpu_idle),
      .eng_done_i      (eng_done),
      .hawk_own_o      (hawk_own),
      .start_o         (start),
      .page_o          (page),
      .busy_o          (comp_busy_o),
      .done_o          (comp_done_o)
   );

endmodule

`default_nettype wire

//--- hacd_cpu_stall.sv
/*
 * sits on the CPU request path. passes requests through while the CPU
 * owns memory, parks one request while the engine owns it, and counts
 * CPU reads in flight so the control unit knows when the drain is over
 */
`default_nettype none

module hacd_cpu_stall
   import hacd_mem_pkg::*;
(
   input  wire logic     clk_i,
   input  wire logic     rst_i,
   input  wire logic     hawk_own_i,      // engine has the port
   input  wire mem_req_t cpu_req_i,
   output mem_req_t      cpu_req_o,
   output logic          cpu_stalled_o,
   output logic          cpu_idle_o,
   input  wire logic     rd_resp_valid_i  // cpu read came back
);

   mem_req_t           held_q;      // parked request, payload only
   logic               held_vld_q;
   logic [OUTST_W-1:0] rd_cnt_q;    // cpu reads in flight
   logic               rd_issue;

   // held request goes out first once the engine lets go
   always_comb begin
      cpu_req_o = cpu_req_i;
      if (held_vld_q)
         cpu_req_o = held_q;
      if (hawk_own_i)
         cpu_req_o.valid = 1'b0;   // nothing from cpu while engine owns
   end

   assign rd_issue      = cpu_req_o.valid && !cpu_req_o.we;
   assign cpu_stalled_o = held_vld_q;
   // a read strobed this cycle still counts as busy
   assign cpu_idle_o    = (rd_cnt_q == '0) && !held_vld_q &&
                          !(cpu_req_i.valid && !cpu_req_i.we);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         held_vld_q <= 1'b0;
         rd_cnt_q   <= '0;
      end else begin
         if (hawk_own_i && cpu_req_i.valid)
            held_vld_q <= 1'b1;
         else if (!hawk_own_i)
            held_vld_q <= 1'b0;   // issued this cycle
         rd_cnt_q <= rd_cnt_q + OUTST_W'(rd_issue) - OUTST_W'(rd_resp_valid_i);
      end
   end

   always_ff @(posedge clk_i) begin
      if (hawk_own_i && cpu_req_i.valid)
         held_q <= cpu_req_i;
   end

   // CPU must wait for the stall to clear before it strobes again
   a_no_strobe_stalled : assert property (@(posedge clk_i) disable iff (rst_i)
      cpu_stalled_o |-> !cpu_req_i.valid);

   // mux only steers a response here if this unit issued the read
   a_rd_cnt_underflow : assert property (@(posedge clk_i) disable iff (rst_i)
      rd_resp_valid_i |-> (rd_cnt_q != '0));

endmodule

`default_nettype wire

//--- hacd_ctrl_unit.sv
/*
 * compression control FSM. takes a request strobe, waits for the CPU
 * reads to drain, hands the memory port to the engine and kicks it,
 * then reports done for one cycle and gives the port back
 */
`default_nettype none

module hacd_ctrl_unit
   import hacd_mem_pkg::*;
   import hacd_comp_pkg::*;
(
   input  wire logic        clk_i,
   input  wire logic        rst_i,
   input  wire logic        hawk_inactive_i,   // software disable
   input  wire logic        comp_req_i,
   input  wire [ADDR_W-1:0] comp_page_i,
   input  wire logic        cpu_idle_i,
   input  wire logic        eng_done_i,
   output logic             hawk_own_o,
   output logic             start_o,
   output logic [ADDR_W-1:0] page_o,
   output logic             busy_o,
   output logic             done_o
);

   ctrl_state_e       state_q;
   ctrl_state_e       state_d;
   logic              start_q;
   logic [ADDR_W-1:0] page_q;

   always_comb begin
      state_d = state_q;
      unique case (state_q)
         CU_IDLE:  if (comp_req_i && !hawk_inactive_i) state_d = CU_DRAIN;
         CU_DRAIN: if (cpu_idle_i) state_d = CU_COMP;
         CU_COMP:  if (eng_done_i) state_d = CU_DONE;
         CU_DONE:  state_d = CU_IDLE;   // single cycle
         default:  state_d = CU_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= CU_IDLE;
         start_q <= 1'b0;
      end else begin
         state_q <= state_d;
         start_q <= (state_q == CU_DRAIN) && cpu_idle_i;   // lines up with own
      end
   end

   // page address, taken only on an accepted request
   always_ff @(posedge clk_i) begin
      if (state_q == CU_IDLE && comp_req_i && !hawk_inactive_i)
         page_q <= comp_page_i;
   end

   assign hawk_own_o = (state_q == CU_COMP);
   assign start_o    = start_q;
   assign page_o     = page_q;
   assign busy_o     = (state_q == CU_DRAIN) || (state_q == CU_COMP);
   assign done_o     = (state_q == CU_DONE);

   // engine finishes only while it holds the port
   a_done_in_comp : assert property (@(posedge clk_i) disable iff (rst_i)
      eng_done_i |-> (state_q == CU_COMP));

endmodule

`default_nettype wire

//--- hacd_mem_mux.sv
/*
 * two-way mux on the memory port. owner select comes straight from the
 * control unit, read data fans out to both sides and only the owner
 * sees a valid
 */
`default_nettype none

module hacd_mem_mux
   import hacd_mem_pkg::*;
(
   input  wire logic      clk_i,
   input  wire logic      rst_i,
   input  wire logic      hawk_own_i,
   input  wire mem_req_t  cpu_req_i,
   input  wire mem_req_t  eng_req_i,
   output mem_req_t       mem_req_o,
   input  wire mem_resp_t mem_resp_i,
   output mem_resp_t      cpu_resp_o,
   output mem_resp_t      eng_resp_o
);

   logic [OUTST_W-1:0] pend_cnt_q;   // reads issued minus returned

   assign mem_req_o = hawk_own_i ? eng_req_i : cpu_req_i;

   always_comb begin
      cpu_resp_o       = mem_resp_i;
      eng_resp_o       = mem_resp_i;
      cpu_resp_o.valid = mem_resp_i.valid && !hawk_own_i;
      eng_resp_o.valid = mem_resp_i.valid && hawk_own_i;
   end

   always_ff @(posedge clk_i) begin
      if (rst_i)
         pend_cnt_q <= '0;
      else
         pend_cnt_q <= pend_cnt_q + OUTST_W'(mem_req_o.valid && !mem_req_o.we)
                                  - OUTST_W'(mem_resp_i.valid);
   end

   // a handover with reads outstanding would send data to the wrong side
   a_own_stable : assert property (@(posedge clk_i) disable iff (rst_i)
      (hawk_own_i != $past(hawk_own_i)) |-> (pend_cnt_q == '0));

endmodule

`default_nettype wire

//--- hacd_mem_pkg.sv
/*
 * memory port definitions shared by the CPU side, the compression engine
 * and the memory model. every requester drives a mem_req_t, every read
 * comes back as a mem_resp_t with a one-cycle valid pulse
 */
`default_nettype none

package hacd_mem_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths
   //////////////////////////////////////////////////////////////////////
   localparam int ADDR_W     = 32;   // byte address
   localparam int DATA_W     = 64;   // one cacheline, one beat
   localparam int LINE_BYTES = 8;    // address step between lines
   localparam int OUTST_W    = 5;    // reads in flight, room for page + cpu

   // request strobe, memory always accepts
   typedef struct packed {
      logic              valid;
      logic              we;      // 1 write, 0 read
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } mem_req_t;

   // read return, in order, writes get nothing back
   typedef struct packed {
      logic              valid;
      logic [DATA_W-1:0] rdata;
   } mem_resp_t;

endpackage

`default_nettype wire

//--- hacd_zero_comp.sv
/*
 * zero-chunk compression engine. on start it strobes one read per line
 * of the page on back to back cycles, counts the non-zero chunks of each
 * returned line and, one cycle after the last line, pulses done with the
 * compressed size and incompressible flag
 */
`default_nettype none

module hacd_zero_comp
   import hacd_mem_pkg::*;
   import hacd_comp_pkg::*;
(
   input  wire logic        clk_i,
   input  wire logic        rst_i,
   input  wire logic        start_i,
   input  wire [ADDR_W-1:0] page_i,      // held by control unit
   output mem_req_t         eng_req_o,
   input  wire mem_resp_t   eng_resp_i,
   output logic             done_o,
   output comp_result_t     result_o
);

   localparam int IDX_W  = $clog2(LINES_PER_PAGE);
   localparam int CNT_W  = $clog2(PAGE_CHUNKS + 1);
   localparam int LNZ_W  = $clog2(CHUNKS_PER_LINE + 1);

   logic             issuing_q;
   logic [IDX_W-1:0] iss_idx_q;   // next line to request
   logic [IDX_W-1:0] ret_idx_q;   // lines returned so far
   logic [CNT_W-1:0] nz_cnt_q;    // running non-zero chunk count
   logic [LNZ_W-1:0] line_nz;
   logic [CNT_W-1:0] nz_next;
   logic [SIZE_W-1:0] size_next;
   logic             last_resp;
   logic             done_q;
   comp_result_t     result_q;

   //////////////////////////////////////////////////////////////////////
   // read issue
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      eng_req_o       = '0;
      eng_req_o.valid = issuing_q;
      eng_req_o.we    = 1'b0;   // engine only reads
      eng_req_o.addr  = page_i + ADDR_W'(iss_idx_q) * ADDR_W'(LINE_BYTES);
   end

   //////////////////////////////////////////////////////////////////////
   // zero detect on the returning line
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      line_nz = '0;
      for (int i = 0; i < CHUNKS_PER_LINE; i++) begin
         if (eng_resp_i.rdata[i*CHUNK_W +: CHUNK_W] != '0)
            line_nz = line_nz + 1'b1;
      end
   end

   assign nz_next   = nz_cnt_q + CNT_W'(line_nz);
   assign size_next = SIZE_W'(nz_next) * SIZE_W'(CHUNK_BYTES);
   assign last_resp = eng_resp_i.valid && (ret_idx_q == IDX_W'(LINES_PER_PAGE - 1));

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         issuing_q <= 1'b0;
         iss_idx_q <= '0;
         ret_idx_q <= '0;
         nz_cnt_q  <= '0;
         done_q    <= 1'b0;
         result_q  <= '0;
      end else begin
         done_q <= last_resp;   // one cycle after the last line
         if (start_i) begin
            issuing_q <= 1'b1;
            iss_idx_q <= '0;
            ret_idx_q <= '0;
            nz_cnt_q  <= '0;
         end else begin
            if (issuing_q) begin
               iss_idx_q <= iss_idx_q + 1'b1;
               if (iss_idx_q == IDX_W'(LINES_PER_PAGE - 1))
                  issuing_q <= 1'b0;   // whole page requested
            end
            if (eng_resp_i.valid) begin
               ret_idx_q <= ret_idx_q + 1'b1;
               nz_cnt_q  <= nz_next;
            end
            if (last_resp) begin
               result_q.size           <= size_next;
               result_q.incompressible <= size_next > SIZE_W'(INCOMP_BYTES);
            end
         end
      end
   end

   assign done_o   = done_q;
   assign result_o = result_q;   // held until the next page finishes

endmodule

`default_nettype wire

//--- project.f
hacd_mem_pkg.sv
hacd_comp_pkg.sv
hacd_cpu_stall.sv
hacd_mem_mux.sv
hacd_zero_comp.sv
hacd_ctrl_unit.sv
hacd_core.sv
tb_mem_model.sv
tb_hacd_core.sv

//--- tb_hacd_core.sv
/*
 * testbench for the compression core. drives CPU traffic and compression
 * requests on falling edges, concurrent assertions below do the checking,
 * one line per test and a closing count line at the end
 */
`default_nettype none

module tb_hacd_core
   import hacd_mem_pkg::*, hacd_comp_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   // about 500 cycles of tests plus a generous margin
   localparam int MAX_CYCLES = 4000;
   localparam int MEM_LINES  = 256;
   localparam int EXP_D      = 16;   // expected read data queue
   localparam int PAGE_BYTES = LINES_PER_PAGE * LINE_BYTES;

   logic              clk;
   logic              rst;
   logic              hawk_inactive;
   mem_req_t          cpu_req;
   mem_resp_t         cpu_resp;
   logic              cpu_stalled;
   logic              comp_req;
   logic [ADDR_W-1:0] comp_page;
   logic              comp_busy;
   logic              comp_done;
   comp_result_t      comp_result;
   mem_req_t          mem_req;
   mem_resp_t         mem_resp;

   logic [DATA_W-1:0] ref_mem [MEM_LINES];   // what the cpu wrote
   logic [DATA_W-1:0] exp_data [EXP_D];
   int unsigned       exp_wr = 0;
   int unsigned       exp_rd = 0;
   logic [SIZE_W-1:0] exp_size = '0;
   logic [ADDR_W-1:0] cur_page = '0;
   logic [ADDR_W-1:0] stall_addr = '0;
   logic              stall_seen = 1'b0;
   int unsigned       cyc = 0;
   int                err_cnt = 0;
   int                test_cnt = 0;
   int                fail_cnt = 0;
   int                test_err_base = 0;
   logic [31:0]       lfsr_q = 32'h4c32_497c;

   hacd_core i_dut (
      .clk_i           (clk),
      .rst_i           (rst),
      .hawk_inactive_i (hawk_inactive),
      .cpu_req_i       (cpu_req),
      .cpu_resp_o      (cpu_resp),
      .cpu_stalled_o   (cpu_stalled),
      .comp_req_i      (comp_req),
      .comp_page_i     (comp_page),
      .comp_busy_o     (comp_busy),
      .comp_done_o     (comp_done),
      .comp_result_o   (comp_result),
      .mem_req_o       (mem_req),
      .mem_resp_i      (mem_resp)
   );

   tb_mem_model u_mem (
      .clk_i      (clk),
      .rst_i      (rst),
      .mem_req_i  (mem_req),
      .mem_resp_o (mem_resp)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // cycle count, read retire, stall seen, and the run limit
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (!rst && cpu_resp.valid)
         exp_rd <= exp_rd + 1;
      if (cpu_stalled)
         stall_seen <= 1'b1;
      if (cyc == MAX_CYCLES) begin
         $display("timeout after %0d cycles, a test never finished", cyc);
         $display("=== FAIL ===");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // helpers
   //////////////////////////////////////////////////////////////////////
   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         r      = {r[62:0], fb};
      end
      return r;
   endfunction

   function automatic int line_of(input logic [ADDR_W-1:0] addr);
      return int'((addr / LINE_BYTES) % MEM_LINES);
   endfunction

   task automatic report_mismatch(input string sig, input logic [127:0] got,
                                  input logic [127:0] exp);
      err_cnt++;
      $display("[ERROR] %0d ns %s got %0h expected %0h", $time, sig, got, exp);
   endtask

   task automatic note_failure(input string what);
      err_cnt++;
      $display("%0d ns: %s", $time, what);
   endtask

   //////////////////////////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////////////////////////
   a_reset_quiet : assert property (@(posedge clk) rst |=>
      (!comp_busy && !comp_done && !cpu_stalled && !cpu_resp.valid && !mem_req.valid))
      else note_failure("an output was not low right after reset");

   a_resp_expected : assert property (@(posedge clk) disable iff (rst)
      cpu_resp.valid |-> (exp_rd != exp_wr))
      else note_failure("cpu read response with no cpu read outstanding");

   a_cpu_rdata : assert property (@(posedge clk) disable iff (rst)
      (cpu_resp.valid && exp_rd != exp_wr) |-> (cpu_resp.rdata == exp_data[exp_rd % EXP_D]))
      else report_mismatch("cpu_resp_o.rdata", $sampled(cpu_resp.rdata),
                           $sampled(exp_data[exp_rd % EXP_D]));

   // free port sends the request straight to memory
   a_cpu_passthru : assert property (@(posedge clk) disable iff (rst)
      (cpu_req.valid && !cpu_stalled && !i_dut.hawk_own) |-> (mem_req == cpu_req))
      else report_mismatch("mem_req_o", $sampled(mem_req), $sampled(cpu_req));

   a_stall_raise : assert property (@(posedge clk) disable iff (rst)
      (cpu_req.valid && i_dut.hawk_own) |=> cpu_stalled)
      else report_mismatch("cpu_stalled_o", $sampled(cpu_stalled), 1);

   // only engine page reads while the cpu waits
   a_stall_hold : assert property (@(posedge clk) disable iff (rst)
      (cpu_stalled && !comp_done && mem_req.valid) |-> (!mem_req.we &&
         mem_req.addr >= cur_page && mem_req.addr < cur_page + ADDR_W'(PAGE_BYTES)))
      else note_failure("a cpu request reached memory while the cpu was stalled");

   a_held_issue : assert property (@(posedge clk) disable iff (rst)
      (cpu_stalled && comp_done) |-> (mem_req.valid && mem_req.addr == stall_addr))
      else report_mismatch("mem_req_o.addr", $sampled(mem_req.addr), $sampled(stall_addr));

   a_busy_rise : assert property (@(posedge clk) disable iff (rst)
      (comp_req && !hawk_inactive && !comp_busy && !comp_done) |=> comp_busy)
      else report_mismatch("comp_busy_o", $sampled(comp_busy), 1);

   a_inactive_idle : assert property (@(posedge clk) disable iff (rst)
      hawk_inactive |-> !comp_busy)
      else note_failure("compression started while hawk_inactive_i was high");

   a_done_ends_busy : assert property (@(posedge clk) disable iff (rst)
      comp_done |-> (!comp_busy && $past(comp_busy)))
      else note_failure("comp_busy_o did not fall together with comp_done_o");

   a_result_size : assert property (@(posedge clk) disable iff (rst)
      comp_done |-> (comp_result.size == exp_size))
      else report_mismatch("comp_result_o.size", $sampled(comp_result.size),
                           $sampled(exp_size));

   a_result_incomp : assert property (@(posedge clk) disable iff (rst)
      comp_done |-> (comp_result.incompressible == (exp_size > INCOMP_BYTES)))
      else report_mismatch("comp_result_o.incompressible",
                           $sampled(comp_result.incompressible),
                           $sampled(exp_size > INCOMP_BYTES));

   //////////////////////////////////////////////////////////////////////
   // stimulus tasks start and end just after a falling edge
   //////////////////////////////////////////////////////////////////////
   task automatic cpu_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      while (cpu_stalled)
         @(negedge clk);
      cpu_req.valid = 1'b1;
      cpu_req.we    = 1'b1;
      cpu_req.addr  = addr;
      cpu_req.wdata = data;
      ref_mem[line_of(addr)] = data;
      @(negedge clk);
      cpu_req = '0;
   endtask

   task automatic cpu_read(input logic [ADDR_W-1:0] addr);
      while (cpu_stalled)
         @(negedge clk);
      cpu_req.valid = 1'b1;
      cpu_req.we    = 1'b0;
      cpu_req.addr  = addr;
      exp_data[exp_wr % EXP_D] = ref_mem[line_of(addr)];
      exp_wr++;
      @(negedge clk);
      cpu_req = '0;
   endtask

   task automatic wait_reads();
      while (exp_rd != exp_wr)
         @(negedge clk);
   endtask

   // zero_mode 0 all zero, 1 none zero, 2 half, 3 a quarter of chunks zero
   task automatic fill_page(input logic [ADDR_W-1:0] base, input int zero_mode);
      logic [DATA_W-1:0] d;
      for (int l = 0; l < LINES_PER_PAGE; l++) begin
         d = take_bits(DATA_W) | 64'h0001_0001_0001_0001;   // every chunk non-zero
         for (int c = 0; c < CHUNKS_PER_LINE; c++) begin
            if (zero_mode == 0 || (zero_mode == 2 && take_bits(1) == 1) ||
                (zero_mode == 3 && take_bits(2) == 3))
               d[c*CHUNK_W +: CHUNK_W] = '0;
         end
         cpu_write(base + ADDR_W'(l * LINE_BYTES), d);
      end
   endtask

   // expected size from what was written before the request strobe
   task automatic start_compress(input logic [ADDR_W-1:0] base);
      int nz;
      nz = 0;
      for (int l = 0; l < LINES_PER_PAGE; l++) begin
         for (int c = 0; c < CHUNKS_PER_LINE; c++) begin
            if (ref_mem[line_of(base) + l][c*CHUNK_W +: CHUNK_W] != '0)
               nz++;
         end
      end
      exp_size  = SIZE_W'(nz * CHUNK_BYTES);
      cur_page  = base;
      comp_req  = 1'b1;
      comp_page = base;
      @(negedge clk);
      comp_req = 1'b0;
   endtask

   task automatic wait_done();
      while (!comp_done)
         @(negedge clk);
      @(negedge clk);
   endtask

   task automatic end_test(input string name);
      test_cnt++;
      if (err_cnt != test_err_base) begin
         fail_cnt++;
         $display("test %0d %s: failed, %0d errors", test_cnt, name, err_cnt - test_err_base);
      end else begin
         $display("test %0d %s: ok", test_cnt, name);
      end
      test_err_base = err_cnt;
   endtask

   initial begin
      rst           = 1'b1;
      hawk_inactive = 1'b0;
      cpu_req       = '0;
      comp_req      = 1'b0;
      comp_page     = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      end_test("reset state");

      cpu_write(32'h100, take_bits(DATA_W));
      cpu_read(32'h100);
      wait_reads();
      for (int i = 0; i < 4; i++)
         cpu_write(32'h200 + ADDR_W'(i * LINE_BYTES), take_bits(DATA_W));
      for (int i = 0; i < 4; i++)
         cpu_read(32'h200 + ADDR_W'(i * LINE_BYTES));   // back to back
      wait_reads();
      end_test("cpu write and read");

      for (int p = 0; p < 4; p++) begin
         fill_page(32'h400 + ADDR_W'(p * PAGE_BYTES), p);
         start_compress(32'h400 + ADDR_W'(p * PAGE_BYTES));
         wait_done();
      end
      end_test("page compression");

      fill_page(32'h500, 2);
      cpu_write(32'h600, take_bits(DATA_W));
      stall_addr = 32'h600;
      stall_seen = 1'b0;
      start_compress(32'h500);
      // first page read on the port means the engine owns memory
      while (!(mem_req.valid && mem_req.addr == cur_page))
         @(negedge clk);
      cpu_read(32'h600);
      wait_done();
      wait_reads();
      if (!stall_seen)
         note_failure("cpu read during compression was never stalled");
      end_test("cpu stall");

      hawk_inactive = 1'b1;
      @(negedge clk);
      comp_req  = 1'b1;
      comp_page = 32'h400;
      @(negedge clk);
      comp_req = 1'b0;
      cpu_write(32'h700, take_bits(DATA_W));
      cpu_read(32'h700);
      cpu_read(32'h100);
      wait_reads();
      repeat (4) @(negedge clk);
      hawk_inactive = 1'b0;
      end_test("disabled compression");

      $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
      if (err_cnt == 0 && fail_cnt == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb_mem_model.sv
/*
 * behavioural memory for the testbench. accepts every request strobe,
 * answers reads in order after 1 to 8 cycles of random latency, writes
 * get no response
 */
`default_nettype none

module tb_mem_model
   import hacd_mem_pkg::*;
(
   input  wire logic      clk_i,
   input  wire logic      rst_i,
   input  wire mem_req_t  mem_req_i,
   output mem_resp_t      mem_resp_o
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int DEPTH = 256;   // lines, 2 KB of address space
   localparam int QD    = 16;    // read return queue

   logic [DATA_W-1:0] mem [DEPTH];
   logic [DATA_W-1:0] q_data [QD];   // data captured at issue
   int unsigned       q_due [QD];    // cycle the response goes out
   int unsigned       q_wr;
   int unsigned       q_rd;
   int unsigned       cyc;
   int unsigned       last_due;
   int unsigned       due;
   logic [31:0]       lfsr_q = 32'h4c32_497c;

   // fibonacci lfsr x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         r      = {r[62:0], fb};
      end
      return r;
   endfunction

   always @(posedge clk_i) begin
      if (rst_i) begin
         mem_resp_o <= '0;
         q_wr     = 0;
         q_rd     = 0;
         cyc      = 0;
         last_due = 0;
      end else begin
         cyc = cyc + 1;
         mem_resp_o.valid <= 1'b0;
         // head of queue due now, one pulse per response
         if (q_rd != q_wr && q_due[q_rd % QD] == cyc) begin
            mem_resp_o.valid <= 1'b1;
            mem_resp_o.rdata <= q_data[q_rd % QD];
            q_rd = q_rd + 1;
         end
         if (mem_req_i.valid && mem_req_i.we) begin
            mem[(mem_req_i.addr / LINE_BYTES) % DEPTH] = mem_req_i.wdata;
         end else if (mem_req_i.valid) begin
            due = cyc + 1 + int'(take_bits(3));   // 1..8 cycles
            if (due <= last_due)
               due = last_due + 1;   // keep returns in order
            last_due          = due;
            q_due[q_wr % QD]  = due;
            q_data[q_wr % QD] = mem[(mem_req_i.addr / LINE_BYTES) % DEPTH];
            q_wr = q_wr + 1;
         end
      end
   end

endmodule

`default_nettype wire
